/* hw/invadersPkg.sv */
package invadersPkg;

    localparam int CoordWidth = 8;

    typedef logic [7:0] rgbT;
    typedef logic [CoordWidth-1:0] coordT;

    typedef struct packed {
        logic moveLeft;
        logic moveRight;
        logic fire;
    } cmdT;

    typedef struct packed {
        coordT x;
        coordT y;
        rgbT   rgb;
        logic  frameStart;
    } pixelT;

    // Colours are RRRGGGBB
    localparam rgbT BackgroundColor = 8'h00;
    localparam rgbT PlayerColor     = 8'h1c;
    localparam rgbT MissileColor    = 8'hfc;
    localparam rgbT MonsterColor    = 8'he0;

    localparam coordT PlayerWidth  = 4;
    localparam coordT PlayerHeight = 2;
    localparam coordT PlayerStep   = 2;

    localparam coordT MonsterX     = 4;  // Left edge of monster 0
    localparam coordT MonsterSize  = 4;
    localparam coordT MonsterPitch = 8;
    localparam coordT MonsterY     = 4;

    localparam coordT MissileStep  = 3;

endpackage

/* hw/pixelScanner.sv */
`timescale 1ns/10ps

module pixelScanner
    import invadersPkg::*;
#(
    parameter int FrameWidth  = 32,
    parameter int FrameHeight = 24
) (
    input  logic  clk,
    input  logic  rst,
    output coordT x,
    output coordT y,
    output logic  frameStart
);

    localparam coordT LastX = coordT'(FrameWidth - 1);
    localparam coordT LastY = coordT'(FrameHeight - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else if (x == LastX) begin
            x <= '0;
            // Row counter wraps together with the last column of the frame
            y <= (y == LastY) ? '0 : y + coordT'(1);
        end else begin
            x <= x + coordT'(1);
        end
    end

    assign frameStart = (x == '0) && (y == '0);

endmodule

/* hw/playerShip.sv */
`timescale 1ns/10ps

module playerShip
    import invadersPkg::*;
#(
    parameter int FrameWidth  = 32,
    parameter int FrameHeight = 24
) (
    input  logic  clk,
    input  logic  rst,
    input  coordT x,
    input  coordT y,
    input  logic  frameStart,
    input  cmdT   cmd,
    input  logic  cmdValid,
    input  logic  missileHit,
    output logic  cmdReady,
    output logic  playerDraw,
    output logic  missileDraw
);

    localparam coordT PlayerTop = coordT'(FrameHeight - PlayerHeight);
    localparam coordT MaxX      = coordT'(FrameWidth - PlayerWidth);
    localparam coordT StartX    = 14;

    cmdT   pendCmd;
    logic  pending;
    coordT playerX;
    coordT nextX;
    logic  launch;
    logic  missileActive;
    coordT missileX;
    coordT missileY;  // Top row of the missile

    assign cmdReady = !pending;

    always_comb begin
        nextX = playerX;
        if (pending && pendCmd.moveLeft && !pendCmd.moveRight) begin
            nextX = (playerX < PlayerStep) ? '0 : playerX - PlayerStep;
        end else if (pending && pendCmd.moveRight && !pendCmd.moveLeft) begin
            nextX = (playerX + PlayerStep > MaxX) ? MaxX : playerX + PlayerStep;
        end
    end

    assign launch = pending && pendCmd.fire && !missileActive;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending       <= 1'b0;
            playerX       <= StartX;
            missileActive <= 1'b0;
        end else begin
            if (frameStart && pending) begin
                pending <= 1'b0;
            end else if (cmdValid && cmdReady) begin
                pending <= 1'b1;
            end
            if (frameStart) begin
                playerX <= nextX;
                if (missileActive) begin
                    // Leaves the screen instead of wrapping past row 0
                    if (missileHit || missileY < MissileStep) missileActive <= 1'b0;
                end else if (launch) begin
                    missileActive <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmdValid && cmdReady) pendCmd <= cmd;
        if (frameStart && missileActive) begin
            missileY <= missileY - MissileStep;
        end else if (frameStart && launch) begin
            missileX <= nextX + coordT'(1);
            missileY <= PlayerTop - coordT'(2);
        end
    end

    assign playerDraw = (x >= playerX) && (x < playerX + PlayerWidth)
                     && (y >= PlayerTop) && (y < PlayerTop + PlayerHeight);

    assign missileDraw = missileActive && (x == missileX)
                      && ((y == missileY) || (y == missileY + coordT'(1)));

endmodule

/* hw/monsterRow.sv */
`timescale 1ns/10ps

module monsterRow
    import invadersPkg::*;
#(
    parameter int NumMonsters = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  coordT                  x,
    input  coordT                  y,
    input  logic [NumMonsters-1:0] hitMask,
    output logic [NumMonsters-1:0] monsterDraw,
    output coordT                  score
);

    logic [NumMonsters-1:0] alive;
    logic [NumMonsters-1:0] killed;
    coordT                  killCount;

    // A monster already dead cannot be counted twice
    assign killed = hitMask & alive;

    always_comb begin
        killCount = '0;
        for (int i = 0; i < NumMonsters; i++) begin
            killCount = killCount + coordT'(killed[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alive <= '1;
            score <= '0;
        end else begin
            alive <= alive & ~killed;
            score <= score + killCount;
        end
    end

    for (genvar i = 0; i < NumMonsters; i++) begin : gMonster
        localparam coordT Left = coordT'(MonsterX + i * MonsterPitch);

        assign monsterDraw[i] = alive[i]
                             && (x >= Left) && (x < Left + MonsterSize)
                             && (y >= MonsterY) && (y < MonsterY + MonsterSize);
    end

endmodule

/* hw/hitDetection.sv */
`timescale 1ns/10ps

module hitDetection #(
    parameter int NumMonsters = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frameStart,
    input  logic                   missileDraw,
    input  logic [NumMonsters-1:0] monsterDraw,
    output logic [NumMonsters-1:0] hitMask,
    output logic                   missileHit
);

    logic [NumMonsters-1:0] overlap;
    logic [NumMonsters-1:0] hitAcc;

    assign overlap = monsterDraw & {NumMonsters{missileDraw}};

    // The origin pixel opens a new frame, so it seeds the accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            hitAcc <= '0;
        end else if (frameStart) begin
            hitAcc <= overlap;
        end else begin
            hitAcc <= hitAcc | overlap;
        end
    end

    // The accumulator holds the full previous frame while frameStart is high
    assign hitMask    = frameStart ? hitAcc : '0;
    assign missileHit = |hitMask;

endmodule

/* hw/videoMixer.sv */
`timescale 1ns/10ps

module videoMixer
    import invadersPkg::*;
#(
    parameter int NumMonsters = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  coordT                  x,
    input  coordT                  y,
    input  logic                   frameStart,
    input  logic                   playerDraw,
    input  logic                   missileDraw,
    input  logic [NumMonsters-1:0] monsterDraw,
    output pixelT                  pixelOut,
    output logic                   pixelValid
);

    rgbT color;

    always_comb begin
        if (missileDraw) begin
            color = MissileColor;
        end else if (|monsterDraw) begin
            color = MonsterColor;
        end else if (playerDraw) begin
            color = PlayerColor;
        end else begin
            color = BackgroundColor;
        end
    end

    always_ff @(posedge clk) begin
        pixelOut.x          <= x;
        pixelOut.y          <= y;
        pixelOut.rgb        <= color;
        pixelOut.frameStart <= frameStart;  // Travels with its own pixel
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pixelValid <= 1'b0;
        end else begin
            pixelValid <= 1'b1;
        end
    end

endmodule

/* hw/invadersTop.sv */
`timescale 1ns/10ps

module invadersTop
    import invadersPkg::*;
#(
    parameter int FrameWidth  = 32,
    parameter int FrameHeight = 24,
    parameter int NumMonsters = 3
) (
    input  logic  clk,
    input  logic  rst,
    input  cmdT   cmd,
    input  logic  cmdValid,
    output logic  cmdReady,
    output pixelT pixelOut,
    output logic  pixelValid,
    output coordT score
);

    coordT                  x;
    coordT                  y;
    logic                   frameStart;
    logic                   playerDraw;
    logic                   missileDraw;
    logic [NumMonsters-1:0] monsterDraw;
    logic [NumMonsters-1:0] hitMask;
    logic                   missileHit;

    pixelScanner #(.FrameWidth(FrameWidth), .FrameHeight(FrameHeight)) u_pixelScanner (
        .clk        (clk),
        .rst        (rst),
        .x          (x),
        .y          (y),
        .frameStart (frameStart));

    playerShip #(.FrameWidth(FrameWidth), .FrameHeight(FrameHeight)) u_playerShip (
        .clk         (clk),
        .rst         (rst),
        .x           (x),
        .y           (y),
        .frameStart  (frameStart),
        .cmd         (cmd),
        .cmdValid    (cmdValid),
        .missileHit  (missileHit),
        .cmdReady    (cmdReady),
        .playerDraw  (playerDraw),
        .missileDraw (missileDraw));

    monsterRow #(.NumMonsters(NumMonsters)) u_monsterRow (
        .clk         (clk),
        .rst         (rst),
        .x           (x),
        .y           (y),
        .hitMask     (hitMask),
        .monsterDraw (monsterDraw),
        .score       (score));

    hitDetection #(.NumMonsters(NumMonsters)) u_hitDetection (
        .clk         (clk),
        .rst         (rst),
        .frameStart  (frameStart),
        .missileDraw (missileDraw),
        .monsterDraw (monsterDraw),
        .hitMask     (hitMask),
        .missileHit  (missileHit));

    videoMixer #(.NumMonsters(NumMonsters)) u_videoMixer (
        .clk         (clk),
        .rst         (rst),
        .x           (x),
        .y           (y),
        .frameStart  (frameStart),
        .playerDraw  (playerDraw),
        .missileDraw (missileDraw),
        .monsterDraw (monsterDraw),
        .pixelOut    (pixelOut),
        .pixelValid  (pixelValid));

endmodule

/* sim/tbClock.sv */
`timescale 1ns/10ps

module tbClock #(
    parameter int HalfPeriod  = 50,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;  // Released on a rising edge like any other stimulus
    end

endmodule

/* sim/invadersTb.sv */
`timescale 1ns/10ps

module invadersTb
    import invadersPkg::*;
();

    localparam int FrameWidth  = 32;
    localparam int FrameHeight = 24;
    localparam int NumMonsters = 3;
    localparam int PlayerTop   = FrameHeight - int'(PlayerHeight);
    localparam int MaxPlayerX  = FrameWidth - int'(PlayerWidth);
    localparam int WatchdogNs  = 40 * FrameWidth * FrameHeight * 100;

    localparam cmdT LeftCmd  = '{moveLeft: 1'b1, moveRight: 1'b0, fire: 1'b0};
    localparam cmdT RightCmd = '{moveLeft: 1'b0, moveRight: 1'b1, fire: 1'b0};
    localparam cmdT FireCmd  = '{moveLeft: 1'b0, moveRight: 1'b0, fire: 1'b1};

    logic  clk;
    logic  rst;
    cmdT   cmd;
    logic  cmdValid;
    logic  cmdReady;
    pixelT pixelOut;
    logic  pixelValid;
    coordT score;

    // Reference model state
    int               mPlayerX = 14;
    bit               mMissileActive = 1'b0;
    int               mMissileX;
    int               mMissileY;
    bit [NumMonsters-1:0] mAlive = '1;
    bit [NumMonsters-1:0] hitAcc = '0;
    int               mScore = 0;
    bit               mPending = 1'b0;
    cmdT              mCmd;
    time              acceptTime;

    bit resetSeen = 1'b0;
    int expX = 0;
    int expY = 0;
    int frameCount = 0;
    int curMissile = 0;
    int curMonster = 0;
    int curPlayerLeft = 255;
    int lastMissile = 0;
    int lastMonster = 0;
    int lastPlayerLeft = 255;

    int testNum = 0;
    int testChecks = 0;
    int testErrors = 0;
    int checks = 0;
    int errors = 0;

    tbClock u_tbClock (
        .clk (clk),
        .rst (rst));

    invadersTop #(
        .FrameWidth  (FrameWidth),
        .FrameHeight (FrameHeight),
        .NumMonsters (NumMonsters)
    ) u_invadersTop (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmdValid   (cmdValid),
        .cmdReady   (cmdReady),
        .pixelOut   (pixelOut),
        .pixelValid (pixelValid),
        .score      (score));

    task automatic checkThat(input bit ok, input string msg);
        checks++;
        testChecks++;
        assert (ok) else begin
            errors++;
            testErrors++;
            $display("Error: %0d ns: %s", $time, msg);
        end
    endtask

    function automatic bit monsterAt(input int i, input int px, input int py);
        int left;
        left = int'(MonsterX) + i * int'(MonsterPitch);
        return mAlive[i] && px >= left && px < left + int'(MonsterSize)
            && py >= int'(MonsterY) && py < int'(MonsterY) + int'(MonsterSize);
    endfunction

    function automatic bit missileAt(input int px, input int py);
        return mMissileActive && px == mMissileX && (py == mMissileY || py == mMissileY + 1);
    endfunction

    function automatic rgbT expectedColor(input int px, input int py);
        bit anyMonster;
        anyMonster = 1'b0;
        for (int i = 0; i < NumMonsters; i++) anyMonster |= monsterAt(i, px, py);
        if (missileAt(px, py)) return MissileColor;
        if (anyMonster) return MonsterColor;
        if (px >= mPlayerX && px < mPlayerX + int'(PlayerWidth) && py >= PlayerTop) begin
            return PlayerColor;
        end
        return BackgroundColor;
    endfunction

    // Game rules at a frame boundary; the edge lies half a period before this negedge
    task automatic applyFrame();
        bit [NumMonsters-1:0] killed;
        bit useCmd;
        bit launch;
        int nextX;
        killed = hitAcc & mAlive;
        mAlive = mAlive & ~killed;
        for (int i = 0; i < NumMonsters; i++) mScore += int'(killed[i]);
        useCmd = mPending && (acceptTime < $time - 50);
        nextX = mPlayerX;
        if (useCmd && mCmd.moveLeft && !mCmd.moveRight) begin
            nextX = (mPlayerX < int'(PlayerStep)) ? 0 : mPlayerX - int'(PlayerStep);
        end else if (useCmd && mCmd.moveRight && !mCmd.moveLeft) begin
            nextX = (mPlayerX + int'(PlayerStep) > MaxPlayerX) ? MaxPlayerX
                                                               : mPlayerX + int'(PlayerStep);
        end
        launch = useCmd && mCmd.fire && !mMissileActive;
        if (mMissileActive) begin
            if (hitAcc != '0 || mMissileY < int'(MissileStep)) mMissileActive = 1'b0;
            mMissileY -= int'(MissileStep);
        end else if (launch) begin
            mMissileActive = 1'b1;
            mMissileX = nextX + 1;
            mMissileY = PlayerTop - 2;
        end
        mPlayerX = nextX;
        if (useCmd) mPending = 1'b0;
        hitAcc = '0;
    endtask

    always @(negedge clk) begin : monitor
        int px;
        int py;
        rgbT want;
        bit [NumMonsters-1:0] overlap;
        if (rst) begin
            resetSeen = 1'b1;
        end else if (resetSeen) begin
            // The first cycle after reset carries no pixel yet
            checkThat(!pixelValid, "pixelValid is high in the first cycle after reset");
            resetSeen = 1'b0;
        end else if (pixelValid) begin
            px = int'(pixelOut.x);
            py = int'(pixelOut.y);
            checkThat(px == expX && py == expY,
                      $sformatf("pixel (%0d,%0d) where (%0d,%0d) was due", px, py, expX, expY));
            checkThat(pixelOut.frameStart == (px == 0 && py == 0),
                      $sformatf("frameStart %0b at (%0d,%0d)", pixelOut.frameStart, px, py));
            want = expectedColor(px, py);
            checkThat(pixelOut.rgb == want, $sformatf("colour %h at (%0d,%0d), expected %h",
                                                      pixelOut.rgb, px, py, want));
            for (int i = 0; i < NumMonsters; i++) begin
                overlap[i] = monsterAt(i, px, py) && missileAt(px, py);
            end
            if (px == 0 && py == 0) begin
                lastMissile = curMissile;
                lastMonster = curMonster;
                lastPlayerLeft = curPlayerLeft;
                curMissile = 0;
                curMonster = 0;
                curPlayerLeft = 255;
                applyFrame();
                frameCount++;
            end
            hitAcc |= overlap;
            if (pixelOut.rgb == MissileColor) curMissile++;
            if (pixelOut.rgb == MonsterColor) curMonster++;
            if (pixelOut.rgb == PlayerColor && px < curPlayerLeft) curPlayerLeft = px;
            checkThat(cmdReady == !mPending, $sformatf("cmdReady %0b with pending %0b",
                                                       cmdReady, mPending));
            checkThat(score == coordT'(mScore), $sformatf("score %0d, expected %0d", score, mScore));
            expX = (px + 1) % FrameWidth;
            expY = (px + 1 == FrameWidth) ? (py + 1) % FrameHeight : py;
        end
    end

    task automatic waitFrames(input int n);
        int target;
        target = frameCount + n;
        wait (frameCount >= target);
    endtask

    // Returns once the command has been applied at a frame start
    task automatic sendCmd(input cmdT c);
        @(posedge clk);
        cmd      <= c;
        cmdValid <= 1'b1;
        @(negedge clk);
        while (!cmdReady) @(negedge clk);
        @(posedge clk);
        cmdValid   <= 1'b0;
        mCmd       = c;
        acceptTime = $time;
        mPending   = 1'b1;
        wait (!mPending);
        repeat ($urandom % 4) @(posedge clk);
    endtask

    task automatic finishTest(input string name);
        testNum++;
        $display("Test %0d %s: %0d checks, %0d errors", testNum, name, testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    initial begin : watchdog
        #(WatchdogNs);
        $display("Timeout: the run did not finish within 40 frames");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'h0f1ba0c5));
        cmd      = '0;
        cmdValid = 1'b0;
        wait (!rst);
        waitFrames(2);
        finishTest("raster order");
        waitFrames(1);
        finishTest("idle frame");

        // Player starts at x 14, so the missile column 15 lies inside monster 1
        sendCmd(FireCmd);
        waitFrames(1);
        checkThat(lastMissile == 2, $sformatf("%0d missile pixels after launch", lastMissile));
        finishTest("missile rise");

        sendCmd(FireCmd);  // Ignored while the missile is up
        wait (!mMissileActive);
        waitFrames(1);
        checkThat(score == coordT'(1), $sformatf("score %0d after the hit", score));
        checkThat(lastMissile == 0, $sformatf("%0d missile pixels after the hit", lastMissile));
        checkThat(lastMonster == 2 * 16, $sformatf("%0d monster pixels", lastMonster));
        finishTest("monster hit");

        repeat (8) sendCmd(RightCmd);
        sendCmd(LeftCmd);
        checkThat(lastPlayerLeft == MaxPlayerX,
                  $sformatf("player at %0d at the right border", lastPlayerLeft));
        repeat (14) sendCmd(LeftCmd);
        waitFrames(1);
        checkThat(lastPlayerLeft == 0,
                  $sformatf("player at %0d at the left border", lastPlayerLeft));
        finishTest("player moves");

        $display("Summary: %0d tests, %0d checks, %0d errors", testNum, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* invadersTop.f */
hw/invadersPkg.sv
hw/pixelScanner.sv
hw/playerShip.sv
hw/monsterRow.sv
hw/hitDetection.sv
hw/videoMixer.sv
hw/invadersTop.sv
sim/tbClock.sv
sim/invadersTb.sv

/* runSim.sh */
#!/bin/sh
# Builds and runs the invaders testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module invadersTb -f invadersTop.f \
    -Mdir obj_dir -o simInvaders
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/simInvaders > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1
